//--- hw/fcr_cfg.svh
// Command and response controller configuration

`ifndef FCR_CFG_SVH
`define FCR_CFG_SVH

//////////////////////////////////////////////////
// Frame layout

`define FCR_BYTE_W 8
`define FCR_ADR_BYTES 6
`define FCR_DATA_BYTES 9
`define FCR_FRAME_BYTES 17

//////////////////////////////////////////////////
// Setting widths and reset values

`define FCR_VAL_W 12
`define FCR_VNUM_W 16

`define FCR_NSP_RST 11
`define FCR_NOC_RST 10
`define FCR_XMAX_RST 2047
`define FCR_YMAX_RST 1023

`endif

//--- hw/fcr_pkg.sv
// Command and response controller types

`include "fcr_cfg.svh"

package fcr_pkg;

   // Action byte, first byte of a frame
   typedef enum logic [`FCR_BYTE_W-1:0] {
      NOP = 8'h00,
      GET = 8'h01,
      SET = 8'h02
   } fcr_action_e;

   // Parameter byte, second byte of a frame
   typedef enum logic [`FCR_BYTE_W-1:0] {
      VNUM      = 8'h00,
      EL_RUN    = 8'h01,
      EL_TP     = 8'h02,
      DE_NOP    = 8'h03,
      NSP       = 8'h04,
      NOC       = 8'h05,
      X_LOC_MAX = 8'h06,
      Y_LOC_MAX = 8'h07,
      EL_RUN_2  = 8'h08
   } fcr_param_e;

   // One decoded command, MSB first on the wire
   typedef struct packed {
      fcr_action_e                             action;
      fcr_param_e                              param;
      logic [`FCR_ADR_BYTES*`FCR_BYTE_W-1:0]   adr;
      logic [`FCR_DATA_BYTES*`FCR_BYTE_W-1:0]  data;
   } fcr_cmd_t;

   // Response frame, field order is byte order
   typedef struct packed {
      logic                                    err;
      logic [`FCR_BYTE_W-2:0]                  action;
      fcr_param_e                              param;
      logic [`FCR_ADR_BYTES*`FCR_BYTE_W-1:0]   adr;
      logic [`FCR_DATA_BYTES*`FCR_BYTE_W-1:0]  data;
   } fcr_rsp_t;

   // Held settings toward the detector
   typedef struct packed {
      logic [`FCR_VAL_W-1:0] nsp;
      logic [`FCR_VAL_W-1:0] noc;
      logic [`FCR_VAL_W-1:0] x_loc_max;
      logic [`FCR_VAL_W-1:0] y_loc_max;
      logic                  test_pat;
   } fcr_settings_t;

   // Single-cycle control pulses
   typedef struct packed {
      logic el_run;
      logic el_run_2;
      logic de_nop;
   } fcr_pulses_t;

endpackage

//--- hw/fcr_byte_rx.sv
// Command byte receiver

`include "fcr_cfg.svh"

module fcr_byte_rx (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_cmd_req,
   input  logic [`FCR_BYTE_W-1:0] i_cmd_data,
   input  logic                   i_hold,
   output logic                   o_cmd_ack,
   output logic                   o_byte_vld,
   output logic [`FCR_BYTE_W-1:0] o_byte
);

   logic take;

   // New request seen and nothing downstream is holding us off
   assign take = i_cmd_req && !o_cmd_ack && !i_hold;

   //////////////////////////////////////////////////
   // Four-phase handshake

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_cmd_ack  <= 1'b0;
         o_byte_vld <= 1'b0;
      end else begin
         o_byte_vld <= 1'b0;
         if (take) begin
            o_cmd_ack <= 1'b1;
         end else if (o_cmd_ack && !i_cmd_req) begin
            // Host released, byte is complete
            o_cmd_ack  <= 1'b0;
            o_byte_vld <= 1'b1;
         end
      end
   end

   // Byte latched together with the ack
   always_ff @(posedge clk) begin
      if (take) begin
         o_byte <= i_cmd_data;
      end
   end

   // Ack may only rise after a cycle without hold
   a_no_ack_on_hold: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      $rose(o_cmd_ack) |-> $past(!i_hold)
   ) else $error("cmd ack rose while receiver was held");

endmodule

//--- hw/fcr_cmd_parser.sv
// Command frame parser

`include "fcr_cfg.svh"

module fcr_cmd_parser (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_byte_vld,
   input  logic [`FCR_BYTE_W-1:0] i_byte,
   output logic                   o_cmd_vld,
   output fcr_pkg::fcr_cmd_t      o_cmd,
   output logic                   o_in_frame
);

   import fcr_pkg::*;

   localparam int POS_W = $clog2(`FCR_FRAME_BYTES);
   localparam logic [POS_W-1:0] LAST_POS = POS_W'(`FCR_FRAME_BYTES - 1);
   localparam int CMD_W = $bits(fcr_cmd_t);

   logic [POS_W-1:0] pos;
   logic             act_ok;
   logic             shift_en;

   // Only known actions may open a frame
   always_comb begin
      case (i_byte)
         NOP:     act_ok = 1'b1;
         GET:     act_ok = 1'b1;
         SET:     act_ok = 1'b1;
         default: act_ok = 1'b0;
      endcase
   end

   assign shift_en = i_byte_vld && ((pos != '0) || act_ok);

   //////////////////////////////////////////////////
   // Frame position and strobes

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pos        <= '0;
         o_cmd_vld  <= 1'b0;
         o_in_frame <= 1'b0;
      end else begin
         o_cmd_vld <= 1'b0;
         // Frame stays open through the strobe cycle so busy has no gap
         if (o_cmd_vld) begin
            o_in_frame <= 1'b0;
         end
         if (i_byte_vld) begin
            if (pos == '0) begin
               if (act_ok) begin
                  pos        <= pos + 1'b1;
                  o_in_frame <= 1'b1;
               end
            end else if (pos == LAST_POS) begin
               pos       <= '0;
               o_cmd_vld <= 1'b1;
            end else begin
               pos <= pos + 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Field assembly

   // Fields are in wire order, so a byte shift fills them all
   always_ff @(posedge clk) begin
      if (shift_en) begin
         o_cmd <= fcr_cmd_t'({o_cmd[CMD_W-`FCR_BYTE_W-1:0], i_byte});
      end
   end

   a_pos_range: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      pos <= LAST_POS
   ) else $error("frame position past last byte");

endmodule

//--- hw/fcr_cmd_exec.sv
// Command execution and settings

`include "fcr_cfg.svh"

module fcr_cmd_exec (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_cmd_vld,
   input  fcr_pkg::fcr_cmd_t      i_cmd,
   input  logic [`FCR_VNUM_W-1:0] i_vnum,
   output fcr_pkg::fcr_settings_t o_settings,
   output fcr_pkg::fcr_pulses_t   o_pulses,
   output logic                   o_rsp_vld,
   output fcr_pkg::fcr_rsp_t      o_rsp,
   output logic                   o_pending
);

   import fcr_pkg::*;

   localparam int DATA_W = `FCR_DATA_BYTES * `FCR_BYTE_W;

   localparam fcr_settings_t SETTINGS_RST = '{
      nsp:       `FCR_VAL_W'(`FCR_NSP_RST),
      noc:       `FCR_VAL_W'(`FCR_NOC_RST),
      x_loc_max: `FCR_VAL_W'(`FCR_XMAX_RST),
      y_loc_max: `FCR_VAL_W'(`FCR_YMAX_RST),
      test_pat:  1'b0
   };

   logic              nxt_err;
   logic [DATA_W-1:0] nxt_data;
   fcr_settings_t     nxt_set;
   fcr_pulses_t       nxt_pls;

   //////////////////////////////////////////////////
   // Decode

   always_comb begin
      nxt_err  = 1'b0;
      nxt_data = '0;
      nxt_set  = o_settings;
      nxt_pls  = '0;
      case (i_cmd.action)
         NOP: begin
            nxt_data = '0;
         end
         GET: begin
            if (i_cmd.param == VNUM) begin
               nxt_data = DATA_W'(i_vnum);
            end else begin
               nxt_err = 1'b1;
            end
         end
         SET: begin
            case (i_cmd.param)
               EL_RUN: begin
                  nxt_pls.el_run = 1'b1;
                  nxt_data       = DATA_W'(1);
               end
               EL_RUN_2: begin
                  nxt_pls.el_run_2 = 1'b1;
                  nxt_data         = DATA_W'(1);
               end
               DE_NOP: begin
                  nxt_pls.de_nop = 1'b1;
                  nxt_data       = DATA_W'(1);
               end
               EL_TP: begin
                  nxt_set.test_pat = i_cmd.data[0];
                  nxt_data         = DATA_W'(i_cmd.data[0]);
               end
               // Numeric settings take the low bits and echo the whole field
               NSP: begin
                  nxt_set.nsp = i_cmd.data[`FCR_VAL_W-1:0];
                  nxt_data    = i_cmd.data;
               end
               NOC: begin
                  nxt_set.noc = i_cmd.data[`FCR_VAL_W-1:0];
                  nxt_data    = i_cmd.data;
               end
               X_LOC_MAX: begin
                  nxt_set.x_loc_max = i_cmd.data[`FCR_VAL_W-1:0];
                  nxt_data          = i_cmd.data;
               end
               Y_LOC_MAX: begin
                  nxt_set.y_loc_max = i_cmd.data[`FCR_VAL_W-1:0];
                  nxt_data          = i_cmd.data;
               end
               default: nxt_err = 1'b1;
            endcase
         end
         default: nxt_err = 1'b1;
      endcase
   end

   //////////////////////////////////////////////////
   // Settings, pulses and response strobe

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_settings <= SETTINGS_RST;
         o_pulses   <= '0;
         o_rsp_vld  <= 1'b0;
      end else begin
         o_rsp_vld <= i_cmd_vld;
         o_pulses  <= '0;
         if (i_cmd_vld) begin
            o_settings <= nxt_set;
            o_pulses   <= nxt_pls;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cmd_vld) begin
         o_rsp.err    <= nxt_err;
         o_rsp.action <= 7'(i_cmd.action);
         o_rsp.param  <= i_cmd.param;
         o_rsp.adr    <= i_cmd.adr;
         o_rsp.data   <= nxt_data;
      end
   end

   // Bridges the cycle before the transmitter reports busy
   assign o_pending = o_rsp_vld;

   a_one_pulse: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      $onehot0(o_pulses)
   ) else $error("more than one control pulse active");

endmodule

//--- hw/fcr_rsp_tx.sv
// Response frame transmitter

`include "fcr_cfg.svh"

module fcr_rsp_tx (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_rsp_vld,
   input  fcr_pkg::fcr_rsp_t      i_rsp,
   input  logic                   i_rsp_ack,
   output logic                   o_rsp_req,
   output logic [`FCR_BYTE_W-1:0] o_rsp_data,
   output logic                   o_busy
);

   import fcr_pkg::*;

   localparam int RSP_W = $bits(fcr_rsp_t);
   localparam int IDX_W = $clog2(`FCR_FRAME_BYTES);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`FCR_FRAME_BYTES - 1);

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      WAIT_LOW
   } tx_state_e;

   tx_state_e        state;
   logic [IDX_W-1:0] idx;
   logic [RSP_W-1:0] frame;

   // Current byte is always the top of the shift register
   assign o_rsp_data = frame[RSP_W-1 -: `FCR_BYTE_W];
   assign o_busy     = (state != IDLE);

   //////////////////////////////////////////////////
   // Byte sequencing

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= IDLE;
         idx       <= '0;
         o_rsp_req <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_rsp_vld) begin
                  idx       <= '0;
                  o_rsp_req <= 1'b1;
                  state     <= REQ;
               end
            end
            REQ: begin
               if (i_rsp_ack) begin
                  o_rsp_req <= 1'b0;
                  state     <= WAIT_LOW;
               end
            end
            WAIT_LOW: begin
               if (!i_rsp_ack) begin
                  if (idx == LAST_IDX) begin
                     state <= IDLE;
                  end else begin
                     idx       <= idx + 1'b1;
                     o_rsp_req <= 1'b1;
                     state     <= REQ;
                  end
               end
            end
            default: begin
               o_rsp_req <= 1'b0;
               state     <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && i_rsp_vld) begin
         frame <= i_rsp;
      end else if (state == WAIT_LOW && !i_rsp_ack) begin
         frame <= {frame[RSP_W-`FCR_BYTE_W-1:0], {`FCR_BYTE_W{1'b0}}};
      end
   end

   a_req_in_busy: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_rsp_req |-> o_busy
   ) else $error("rsp req high outside a response frame");

endmodule

//--- hw/fcr_ctrl.sv
// Command and response controller top

`include "fcr_cfg.svh"

module fcr_ctrl (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_cmd_req,
   input  logic [`FCR_BYTE_W-1:0] i_cmd_data,
   output logic                   o_cmd_ack,
   output logic                   o_rsp_req,
   output logic [`FCR_BYTE_W-1:0] o_rsp_data,
   input  logic                   i_rsp_ack,
   output logic                   o_busy,
   input  logic [`FCR_VNUM_W-1:0] i_vnum,
   output fcr_pkg::fcr_settings_t o_settings,
   output fcr_pkg::fcr_pulses_t   o_pulses
);

   import fcr_pkg::*;

   logic                   byte_vld;
   logic [`FCR_BYTE_W-1:0] byte_data;
   logic                   cmd_vld;
   fcr_cmd_t               cmd;
   logic                   in_frame;
   logic                   rsp_vld;
   fcr_rsp_t               rsp;
   logic                   pending;
   logic                   tx_busy;
   logic                   hold;

   // No new command bytes while a response is queued or going out
   assign hold   = pending | tx_busy;
   assign o_busy = in_frame | pending | tx_busy;

   fcr_byte_rx u_byte_rx (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cmd_req  (i_cmd_req),
      .i_cmd_data (i_cmd_data),
      .i_hold     (hold),
      .o_cmd_ack  (o_cmd_ack),
      .o_byte_vld (byte_vld),
      .o_byte     (byte_data)
   );

   fcr_cmd_parser u_cmd_parser (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_byte_vld (byte_vld),
      .i_byte     (byte_data),
      .o_cmd_vld  (cmd_vld),
      .o_cmd      (cmd),
      .o_in_frame (in_frame)
   );

   fcr_cmd_exec u_cmd_exec (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cmd_vld  (cmd_vld),
      .i_cmd      (cmd),
      .i_vnum     (i_vnum),
      .o_settings (o_settings),
      .o_pulses   (o_pulses),
      .o_rsp_vld  (rsp_vld),
      .o_rsp      (rsp),
      .o_pending  (pending)
   );

   fcr_rsp_tx u_rsp_tx (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rsp_vld  (rsp_vld),
      .i_rsp      (rsp),
      .i_rsp_ack  (i_rsp_ack),
      .o_rsp_req  (o_rsp_req),
      .o_rsp_data (o_rsp_data),
      .o_busy     (tx_busy)
   );

endmodule

//--- dv/fcr_tb_util.svh
// Testbench helpers: LFSR, reference model, compares

`ifndef FCR_TB_UTIL_SVH
`define FCR_TB_UTIL_SVH

//////////////////////////////////////////////////
// Random bits

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
   logic b;
   b = lfsr[0];
   lfsr = lfsr >> 1;
   if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
   end
   return b;
endfunction

function automatic logic [DATA_W-1:0] rand_bits(input int n);
   logic [DATA_W-1:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      r = {r[DATA_W-2:0], lfsr_bit()};
   end
   return r;
endfunction

//////////////////////////////////////////////////
// Reference model

function automatic fcr_rsp_t expect_rsp(input fcr_cmd_t cmd, input fcr_settings_t cur,
                                        input logic [`FCR_VNUM_W-1:0] vnum,
                                        output fcr_settings_t nxt, output fcr_pulses_t pls);
   fcr_rsp_t               r;
   logic [`FCR_BYTE_W-1:0] act;
   act = cmd.action;
   r.err = 1'b0;
   r.action = act[`FCR_BYTE_W-2:0];
   r.param = cmd.param;
   r.adr = cmd.adr;
   // NOP and every error answer with zero data
   r.data = '0;
   nxt = cur;
   pls = '0;
   if (cmd.action == GET) begin
      if (cmd.param == VNUM) begin
         r.data = DATA_W'(vnum);
      end else begin
         r.err = 1'b1;
      end
   end else if (cmd.action == SET) begin
      case (cmd.param)
         EL_RUN: begin
            pls.el_run = 1'b1;
            r.data = DATA_W'(1);
         end
         EL_RUN_2: begin
            pls.el_run_2 = 1'b1;
            r.data = DATA_W'(1);
         end
         DE_NOP: begin
            pls.de_nop = 1'b1;
            r.data = DATA_W'(1);
         end
         EL_TP: begin
            nxt.test_pat = cmd.data[0];
            r.data = DATA_W'(cmd.data[0]);
         end
         NSP: begin
            nxt.nsp = cmd.data[`FCR_VAL_W-1:0];
            r.data = cmd.data;
         end
         NOC: begin
            nxt.noc = cmd.data[`FCR_VAL_W-1:0];
            r.data = cmd.data;
         end
         X_LOC_MAX: begin
            nxt.x_loc_max = cmd.data[`FCR_VAL_W-1:0];
            r.data = cmd.data;
         end
         Y_LOC_MAX: begin
            nxt.y_loc_max = cmd.data[`FCR_VAL_W-1:0];
            r.data = cmd.data;
         end
         default: r.err = 1'b1;
      endcase
   end
   return r;
endfunction

//////////////////////////////////////////////////
// Compares

task automatic check_rsp(input fcr_rsp_t got, input fcr_rsp_t exp);
   if (got !== exp) begin
      $display("[ERROR] o_rsp_data frame: got 0x%h, expected 0x%h", got, exp);
      err_cnt++;
   end
endtask

task automatic check_settings(input fcr_settings_t got, input fcr_settings_t exp);
   if (got !== exp) begin
      $display("[ERROR] o_settings: got 0x%h, expected 0x%h", got, exp);
      err_cnt++;
   end
endtask

task automatic check_pulse(input fcr_pulses_t got, input fcr_pulses_t exp);
   if (got !== exp) begin
      $display("[ERROR] o_pulses: got 0x%h, expected 0x%h", got, exp);
      err_cnt++;
   end
endtask

`endif

//--- dv/fcr_tb.sv
// Command and response controller testbench

`include "fcr_cfg.svh"

module fcr_tb;

   import fcr_pkg::*;

   localparam int DRV_DLY = 10;
   localparam int DATA_W = `FCR_DATA_BYTES * `FCR_BYTE_W;
   localparam int ADR_W = `FCR_ADR_BYTES * `FCR_BYTE_W;
   localparam int CMD_W = $bits(fcr_cmd_t);
   localparam int RSP_W = $bits(fcr_rsp_t);
   localparam int TEST_BUDGET = 40;
   localparam int MAX_CYC = TEST_BUDGET * `FCR_FRAME_BYTES * 2 * 8;
   localparam logic [`FCR_VNUM_W-1:0] VERSION = 16'h2C51;

   logic                   clk;
   logic                   i_rst_n;
   logic                   i_cmd_req;
   logic [`FCR_BYTE_W-1:0] i_cmd_data;
   logic                   o_cmd_ack;
   logic                   o_rsp_req;
   logic [`FCR_BYTE_W-1:0] o_rsp_data;
   logic                   i_rsp_ack;
   logic                   o_busy;
   logic [`FCR_VNUM_W-1:0] i_vnum;
   fcr_settings_t          o_settings;
   fcr_pulses_t            o_pulses;

   int            err_cnt = 0;
   int            err_mark = 0;
   int            test_cnt = 0;
   int            fail_cnt = 0;
   int            n_rsp = 0;
   int            rsp_delay = 0;
   int            cyc = 0;
   int            pls_cyc = 0;
   logic [31:0]   lfsr = 32'd83761;
   fcr_pulses_t   pls_seen;
   fcr_settings_t exp_set;
   fcr_rsp_t      exp_q[$];

   `include "fcr_tb_util.svh"

   fcr_ctrl u_fcr_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cmd_req  (i_cmd_req),
      .i_cmd_data (i_cmd_data),
      .o_cmd_ack  (o_cmd_ack),
      .o_rsp_req  (o_rsp_req),
      .o_rsp_data (o_rsp_data),
      .i_rsp_ack  (i_rsp_ack),
      .o_busy     (o_busy),
      .i_vnum     (i_vnum),
      .o_settings (o_settings),
      .o_pulses   (o_pulses)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Every host action happens a little after the rising edge
   task automatic step();
      @(posedge clk);
      #DRV_DLY;
   endtask

   //////////////////////////////////////////////////
   // Host driver

   task automatic send_byte(input logic [`FCR_BYTE_W-1:0] b);
      i_cmd_data = b;
      i_cmd_req = 1'b1;
      do step(); while (!o_cmd_ack);
      i_cmd_req = 1'b0;
      do step(); while (o_cmd_ack);
   endtask

   task automatic send_frame(input fcr_cmd_t c);
      logic [CMD_W-1:0] bits;
      bits = c;
      for (int i = 0; i < `FCR_FRAME_BYTES; i++) begin
         send_byte(bits[CMD_W-1-`FCR_BYTE_W*i -: `FCR_BYTE_W]);
      end
   endtask

   function automatic fcr_cmd_t make_cmd(input fcr_action_e a, input fcr_param_e p);
      fcr_cmd_t c;
      c.action = a;
      c.param = p;
      c.adr = ADR_W'(rand_bits(ADR_W));
      c.data = rand_bits(DATA_W);
      return c;
   endfunction

   // Queue the expected response and advance the settings model
   task automatic post_expect(input fcr_cmd_t c, output fcr_pulses_t pls);
      fcr_settings_t nset;
      fcr_rsp_t      r;
      r = expect_rsp(c, exp_set, VERSION, nset, pls);
      exp_q.push_back(r);
      exp_set = nset;
   endtask

   task automatic wait_rsp(input int n);
      while (n_rsp < n) step();
   endtask

   task automatic run_cmd(input fcr_cmd_t c);
      fcr_pulses_t epls;
      int          n0;
      n0 = n_rsp;
      pls_seen = '0;
      pls_cyc = 0;
      post_expect(c, epls);
      send_frame(c);
      wait_rsp(n0 + 1);
      check_settings(o_settings, exp_set);
      check_pulse(pls_seen, epls);
      if (pls_cyc > 1) begin
         $display("control pulse lasted %0d cycles instead of one", pls_cyc);
         err_cnt++;
      end
   endtask

   task automatic set_test(input fcr_param_e p, input string name);
      fcr_cmd_t c;
      for (int i = 0; i < 2; i++) begin
         c = make_cmd(SET, p);
         // Test pattern bit alternates so both edges are seen
         if (p == EL_TP) begin
            c.data[0] = ~exp_set.test_pat;
         end
         run_cmd(c);
      end
      finish_test(name);
   endtask

   // Command acks stay off until the slow response has gone out
   task automatic watch_hold(input int n0);
      logic done;
      done = 1'b0;
      while (!done) begin
         step();
         if (n_rsp != n0) begin
            done = 1'b1;
         end else begin
            if (o_cmd_ack) begin
               $display("command byte acked while a response was still sending");
               err_cnt++;
            end
            if (!o_busy) begin
               $display("o_busy dropped while a response was still sending");
               err_cnt++;
            end
         end
      end
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      if (err_cnt == err_mark) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
         fail_cnt++;
      end
      err_mark = err_cnt;
   endtask

   //////////////////////////////////////////////////
   // Response collector and compare

   initial begin : collector
      logic [RSP_W-1:0] bits;
      i_rsp_ack = 1'b0;
      bits = '0;
      forever begin
         for (int i = 0; i < `FCR_FRAME_BYTES; i++) begin
            do step(); while (!o_rsp_req);
            repeat (rsp_delay) step();
            bits = {bits[RSP_W-`FCR_BYTE_W-1:0], o_rsp_data};
            i_rsp_ack = 1'b1;
            do step(); while (o_rsp_req);
            i_rsp_ack = 1'b0;
         end
         if (exp_q.size() == 0) begin
            $display("response frame arrived with no command expecting one");
            err_cnt++;
         end else begin
            check_rsp(fcr_rsp_t'(bits), exp_q.pop_front());
         end
         n_rsp++;
      end
   end

   // Pulse watch and run limit
   initial begin : monitor
      pls_seen = '0;
      while (cyc < MAX_CYC) begin
         step();
         cyc++;
         if (o_pulses != '0) begin
            pls_seen = pls_seen | o_pulses;
            pls_cyc++;
            if (o_rsp_req) begin
               $display("control pulse seen after the response request rose");
               err_cnt++;
            end
         end
      end
      $display("timeout: run stopped after %0d cycles", cyc);
      $display("TESTS FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Test sequence

   initial begin : test_flow
      fcr_cmd_t    ca;
      fcr_cmd_t    cb;
      fcr_pulses_t epls;
      int          n0;
      i_rst_n = 1'b0;
      i_cmd_req = 1'b0;
      i_cmd_data = '0;
      i_vnum = VERSION;
      exp_set = '{nsp: `FCR_VAL_W'(`FCR_NSP_RST), noc: `FCR_VAL_W'(`FCR_NOC_RST),
                  x_loc_max: `FCR_VAL_W'(`FCR_XMAX_RST),
                  y_loc_max: `FCR_VAL_W'(`FCR_YMAX_RST), test_pat: 1'b0};
      repeat (3) @(posedge clk);
      #DRV_DLY;
      i_rst_n = 1'b1;
      step();

      check_settings(o_settings, exp_set);
      check_pulse(o_pulses, '0);
      if (o_cmd_ack || o_rsp_req || o_busy) begin
         $display("ack, request or busy high after reset");
         err_cnt++;
      end
      finish_test("reset values");

      repeat (3) run_cmd(make_cmd(GET, VNUM));
      finish_test("get vnum");

      set_test(NSP, "set nsp");
      set_test(NOC, "set noc");
      set_test(X_LOC_MAX, "set x_loc_max");
      set_test(Y_LOC_MAX, "set y_loc_max");
      set_test(EL_TP, "set el_tp");

      run_cmd(make_cmd(SET, EL_RUN));
      finish_test("pulse el_run");
      run_cmd(make_cmd(SET, EL_RUN_2));
      finish_test("pulse el_run_2");
      run_cmd(make_cmd(SET, DE_NOP));
      finish_test("pulse de_nop");

      run_cmd(make_cmd(SET, fcr_param_e'(8'h09)));
      finish_test("unknown set param");
      run_cmd(make_cmd(GET, NSP));
      finish_test("unknown get param");
      run_cmd(make_cmd(NOP, VNUM));
      finish_test("nop");

      // Quiet window long enough for any stray response to start
      n0 = n_rsp;
      send_byte(8'h5A);
      repeat (4 * `FCR_FRAME_BYTES) step();
      if (n_rsp != n0 || o_rsp_req || o_busy) begin
         $display("invalid action byte produced activity or left busy high");
         err_cnt++;
      end
      run_cmd(make_cmd(GET, VNUM));
      finish_test("invalid action");

      rsp_delay = 6;
      ca = make_cmd(GET, VNUM);
      cb = make_cmd(SET, NSP);
      n0 = n_rsp;
      post_expect(ca, epls);
      post_expect(cb, epls);
      send_frame(ca);
      do step(); while (!o_rsp_req);
      fork
         send_frame(cb);
         watch_hold(n0);
      join
      wait_rsp(n0 + 2);
      rsp_delay = 0;
      check_settings(o_settings, exp_set);
      finish_test("ack held during slow response");

      $display("%0d tests run, %0d with errors, %0d errors in total",
               test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+hw
+incdir+dv
hw/fcr_pkg.sv
hw/fcr_byte_rx.sv
hw/fcr_cmd_parser.sv
hw/fcr_cmd_exec.sv
hw/fcr_rsp_tx.sv
hw/fcr_ctrl.sv
dv/fcr_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module fcr_tb

sim:
	verilator --binary --timing --assert -f project.f --top-module fcr_tb -o fcr_tb
	./obj_dir/fcr_tb > $(LOG) 2>&1 || echo "TESTS FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
